/* src/sysio_pkg.sv */
/*
 * System I/O package for system-level widths and constants.
 * Covers the system counter, the reset vector base, the
 * peripheral bus base field and the core count.
 */

package sysio_pkg;

  // ==========================================================================
  // Counter and reset vector
  // ==========================================================================

  // Chip-wide system counter, also the machine-timer value
  typedef logic [63:0] sys_cnt_t;

  // Reset vector base from the pads
  typedef logic [63:0] rvba_t;

  // ==========================================================================
  // Peripheral bus base
  // ==========================================================================

  // Full peripheral bus address
  typedef logic [39:0] apb_addr_t;

  // Stored upper field of the base, address bits 39..27
  typedef logic [12:0] apb_base_hi_t;

  // Lowest address bit held in the stored field
  // Bits below it read as zero on the base outputs
  localparam int APB_BASE_LSB = 27;

  // ==========================================================================
  // Cluster size
  // ==========================================================================

  // Cores served by one system I/O block
  localparam int NUM_CORES = 2;

endpackage : sysio_pkg

/* src/sysio_core_pkg.sv */
/*
 * Per-core types for the system I/O block.
 * Interrupt bundle, active-low low-power code and hart number.
 */

package sysio_core_pkg;

  // Hart number, up to eight harts
  typedef logic [2:0] hartid_t;

  // Low-power mode code, active low
  // Run is all ones, stop is all zeros
  typedef enum logic [1:0] {
    LPMD_STOP    = 2'd0,
    LPMD_STANDBY = 2'd1,
    LPMD_WAIT    = 2'd2,
    LPMD_RUN     = 2'd3
  } lpmd_e;

  // Code driven to the pads out of reset
  localparam lpmd_e LPMD_RESET = LPMD_RUN;

  // Interrupt lines of one core
  // External from the PLIC, software and timer from the CLINT
  typedef struct packed {
    logic me;   // Machine external
    logic se;   // Supervisor external
    logic ms;   // Machine software
    logic mt;   // Machine timer
    logic ss;   // Supervisor software
    logic st;   // Supervisor timer
  } core_irq_t;

endpackage : sysio_core_pkg

/* src/gated_clk_cell.sv */
/*
 * Latch-based clock gate.
 * Enable is captured while the clock is low, so the gated
 * clock never glitches. Scan enable forces the clock on.
 */

`timescale 1ns/100ps

module gated_clk_cell (
  input  logic clk_in,
  input  logic en,
  input  logic scan_en,
  output logic clk_out
);

  // Enable held through the high phase
  logic en_lat;

  // Transparent only while clk_in is low
  always_latch
  begin
    if (!clk_in)
      en_lat <= en | scan_en;
  end

  // Pass the high phase only when the latch is set
  assign clk_out = clk_in & en_lat;

endmodule : gated_clk_cell

/* src/sysio_core_ctrl.sv */
/*
 * Per-core system I/O controller.
 * Retimes the six interrupt lines into the bus clock phase,
 * registers the core's low-power code toward the pads and
 * supplies the fixed hart number.
 */

`timescale 1ns/100ps

module sysio_core_ctrl #(
  parameter sysio_core_pkg::hartid_t HART_ID = '0
) (
  input  logic                      apb_base_clk,
  input  logic                      cpurst_b,
  input  logic                      apb_clk_en,
  input  logic                      axim_clk_en,
  input  logic                      pad_yy_icg_scan_en,
  input  sysio_core_pkg::core_irq_t irq_in,
  input  sysio_core_pkg::lpmd_e     core_lpmd,
  output sysio_core_pkg::core_irq_t irq_out,
  output sysio_core_pkg::lpmd_e     pad_lpmd,
  output sysio_core_pkg::hartid_t   hartid
);

  import sysio_core_pkg::*;

  // Gated clocks for the two register groups
  logic irq_gclk;
  logic lpmd_gclk;

  // ==========================================================================
  // Interrupt retiming
  // ==========================================================================

  // Interrupt clock runs only on bus clock strobes
  gated_clk_cell x_irq_gated_clk (
    .clk_in  (apb_base_clk),
    .en      (apb_clk_en),
    .scan_en (pad_yy_icg_scan_en),
    .clk_out (irq_gclk)
  );

  // One register stage for all six lines
  // Enable check keeps scan mode from loading off-strobe
  always_ff @(posedge irq_gclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      irq_out <= '0;
    else if (apb_clk_en)
      irq_out <= irq_in;
  end

  // ==========================================================================
  // Low-power mode
  // ==========================================================================

  // Low-power clock follows the bus master strobe
  gated_clk_cell x_lpmd_gated_clk (
    .clk_in  (apb_base_clk),
    .en      (axim_clk_en),
    .scan_en (pad_yy_icg_scan_en),
    .clk_out (lpmd_gclk)
  );

  // Pads see run mode until the core reports otherwise
  always_ff @(posedge lpmd_gclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pad_lpmd <= LPMD_RESET;
    else if (axim_clk_en)
      pad_lpmd <= core_lpmd;
  end

  // ==========================================================================
  // Hart number
  // ==========================================================================

  // Fixed per instance
  assign hartid = HART_ID;

endmodule : sysio_core_ctrl

/* src/sysio_top.sv */
/*
 * System I/O top for a two-core cluster.
 * Samples the system counter into the machine timer, captures
 * the reset vector during reset, holds the peripheral bus base
 * and hands per-core signals to one controller per core.
 */

`timescale 1ns/100ps

module sysio_top (
  input  logic                      apb_base_clk,
  input  logic                      cpurst_b,
  input  logic                      apb_clk_en,
  input  logic                      axim_clk_en,
  input  logic                      pad_yy_icg_scan_en,
  input  sysio_pkg::sys_cnt_t       pad_cpu_sys_cnt,
  input  sysio_pkg::rvba_t          pad_cpu_rvba,
  input  sysio_pkg::apb_addr_t      pad_cpu_apb_base,
  input  sysio_core_pkg::core_irq_t core_irq_in   [sysio_pkg::NUM_CORES],
  input  sysio_core_pkg::lpmd_e     core_lpmd_in  [sysio_pkg::NUM_CORES],
  output sysio_pkg::sys_cnt_t       clint_mtime,
  output sysio_pkg::rvba_t          sysio_xx_rvba,
  output sysio_pkg::apb_addr_t      sysio_biu_apb_base,
  output sysio_pkg::apb_addr_t      sysio_cp0_apb_base,
  output sysio_core_pkg::core_irq_t core_irq_out  [sysio_pkg::NUM_CORES],
  output sysio_core_pkg::hartid_t   core_hartid   [sysio_pkg::NUM_CORES],
  output sysio_core_pkg::lpmd_e     core_pad_lpmd [sysio_pkg::NUM_CORES]
);

  import sysio_pkg::*;
  import sysio_core_pkg::*;

  // Gated clocks
  logic         ccvr_gclk;
  logic         rvba_gclk;
  logic         base_gclk;

  // Counter sample
  sys_cnt_t     ccvr_q;

  // Reset vector capture flag, high through reset and one edge after
  logic         rvba_rst;

  // Bus base field and its change-detect enable
  apb_base_hi_t base_q;
  apb_base_hi_t base_pad;
  logic         base_en;

  // ==========================================================================
  // System counter sample
  // ==========================================================================

  gated_clk_cell x_ccvr_gated_clk (
    .clk_in  (apb_base_clk),
    .en      (axim_clk_en),
    .scan_en (pad_yy_icg_scan_en),
    .clk_out (ccvr_gclk)
  );

  // Sampled on bus master strobes only
  // Value is undefined before the first strobe
  always_ff @(posedge ccvr_gclk)
  begin
    if (axim_clk_en)
      ccvr_q <= pad_cpu_sys_cnt;
  end

  assign clint_mtime = ccvr_q;

  // ==========================================================================
  // Reset vector capture
  // ==========================================================================

  // Set by reset, dropped on the first edge after release
  always_ff @(posedge apb_base_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rvba_rst <= 1'b1;
    else
      rvba_rst <= 1'b0;
  end

  // Clock stops for good once the flag clears
  gated_clk_cell x_rvba_gated_clk (
    .clk_in  (apb_base_clk),
    .en      (rvba_rst),
    .scan_en (pad_yy_icg_scan_en),
    .clk_out (rvba_gclk)
  );

  // Loads on every edge in reset plus the release edge
  always_ff @(posedge rvba_gclk)
  begin
    if (rvba_rst)
      sysio_xx_rvba <= pad_cpu_rvba;
  end

  // ==========================================================================
  // Peripheral bus base
  // ==========================================================================

  // Upper field of the pad address, lower bits ignored
  assign base_pad = pad_cpu_apb_base[$bits(apb_addr_t)-1:APB_BASE_LSB];

  // Clock only on a strobe where the pad differs from the stored field
  assign base_en = axim_clk_en & (|(base_q ^ base_pad));

  gated_clk_cell x_base_gated_clk (
    .clk_in  (apb_base_clk),
    .en      (base_en),
    .scan_en (pad_yy_icg_scan_en),
    .clk_out (base_gclk)
  );

  always_ff @(posedge base_gclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      base_q <= '0;
    else if (axim_clk_en)
      base_q <= base_pad;
  end

  // Same base to bus unit and coprocessor, zero filled below the field
  assign sysio_biu_apb_base = {base_q, {APB_BASE_LSB{1'b0}}};
  assign sysio_cp0_apb_base = {base_q, {APB_BASE_LSB{1'b0}}};

  // ==========================================================================
  // Per-core controllers
  // ==========================================================================

  // Hart number follows the loop index
  for (genvar i = 0; i < NUM_CORES; i++)
  begin : g_core
    sysio_core_ctrl #(
      .HART_ID (hartid_t'(i))
    ) x_core_ctrl (
      .apb_base_clk       (apb_base_clk),
      .cpurst_b           (cpurst_b),
      .apb_clk_en         (apb_clk_en),
      .axim_clk_en        (axim_clk_en),
      .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
      .irq_in             (core_irq_in[i]),
      .core_lpmd          (core_lpmd_in[i]),
      .irq_out            (core_irq_out[i]),
      .pad_lpmd           (core_pad_lpmd[i]),
      .hartid             (core_hartid[i])
    );
  end

endmodule : sysio_top

/* test/tb_sysio.sv */
/*
 * Testbench for the system I/O top.
 * Replays stimulus records from a trace file, one clock per record,
 * and compares timer, reset vector, bus base and per-core outputs
 * with the expected values that each record carries.
 */

`timescale 1ns/100ps

module tb_sysio;

  import sysio_pkg::*;
  import sysio_core_pkg::*;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 5;
  localparam int    NAME_CHARS   = 24;
  localparam int    FIELD_COUNT  = 17;
  localparam string TRACE_FILE   = "test/sysio_trace.txt";

  // Hart numbers that cores 0 and 1 must report
  localparam hartid_t EXP_HARTID [NUM_CORES] = '{3'd0, 3'd1};

  // Trace record holding stimulus then expected outputs
  typedef struct packed {
    logic [8*NAME_CHARS-1:0]             name;
    logic                                apb_en;
    logic                                axim_en;
    sys_cnt_t                            sys_cnt;
    rvba_t                               rvba;
    apb_addr_t                           apb_base;
    core_irq_t [NUM_CORES-1:0]           irq;
    logic      [NUM_CORES-1:0][1:0]      lpmd;
    logic                                mt_chk;
    sys_cnt_t                            exp_mtime;
    rvba_t                               exp_rvba;
    apb_addr_t                           exp_base;
    core_irq_t [NUM_CORES-1:0]           exp_irq;
    logic      [NUM_CORES-1:0][1:0]      exp_lpmd;
  } trace_rec_t;

  // DUT inputs
  logic      apb_base_clk;
  logic      cpurst_b;
  logic      apb_clk_en;
  logic      axim_clk_en;
  logic      pad_yy_icg_scan_en;
  sys_cnt_t  pad_cpu_sys_cnt;
  rvba_t     pad_cpu_rvba;
  apb_addr_t pad_cpu_apb_base;
  core_irq_t core_irq_in   [NUM_CORES];
  lpmd_e     core_lpmd_in  [NUM_CORES];

  // DUT outputs
  sys_cnt_t  clint_mtime;
  rvba_t     sysio_xx_rvba;
  apb_addr_t sysio_biu_apb_base;
  apb_addr_t sysio_cp0_apb_base;
  core_irq_t core_irq_out  [NUM_CORES];
  hartid_t   core_hartid   [NUM_CORES];
  lpmd_e     core_pad_lpmd [NUM_CORES];

  // Records and bookkeeping
  trace_rec_t recs[$];
  int         errors;
  int         checks;
  int         cycles;
  int         cycle_limit;

  sysio_top sysio_top_inst (
    .apb_base_clk       (apb_base_clk),
    .cpurst_b           (cpurst_b),
    .apb_clk_en         (apb_clk_en),
    .axim_clk_en        (axim_clk_en),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .pad_cpu_sys_cnt    (pad_cpu_sys_cnt),
    .pad_cpu_rvba       (pad_cpu_rvba),
    .pad_cpu_apb_base   (pad_cpu_apb_base),
    .core_irq_in        (core_irq_in),
    .core_lpmd_in       (core_lpmd_in),
    .clint_mtime        (clint_mtime),
    .sysio_xx_rvba      (sysio_xx_rvba),
    .sysio_biu_apb_base (sysio_biu_apb_base),
    .sysio_cp0_apb_base (sysio_cp0_apb_base),
    .core_irq_out       (core_irq_out),
    .core_hartid        (core_hartid),
    .core_pad_lpmd      (core_pad_lpmd)
  );

  // ==========================================================================
  // Clock and timeout
  // ==========================================================================

  initial
  begin
    apb_base_clk = 1'b0;
    forever
      #(CLK_PERIOD/2) apb_base_clk = ~apb_base_clk;
  end

  // Limit armed once the record count is known
  always @(posedge apb_base_clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // ==========================================================================
  // Trace reader
  // ==========================================================================

  task automatic load_trace(output bit ok);
    int                      fd;
    int                      n;
    int                      line_no;
    int                      c;
    string                   line;
    logic [8*NAME_CHARS-1:0] name;
    logic [63:0]             fld [FIELD_COUNT];
    trace_rec_t              rec;
    line_no = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open trace file %s", TRACE_FILE);
      errors = errors + 1;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        line_no = line_no + 1;
        // Skip blank lines and column notes
        if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#")
          continue;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                    fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                    fld[14], fld[15], fld[16]);
        if (n != FIELD_COUNT + 1)
        begin
          $display("ERROR: trace line %0d is short, %0d fields read", line_no, n);
          errors = errors + 1;
        end
        else
        begin
          rec          = '0;
          rec.name     = name;
          rec.apb_en   = fld[0][0];
          rec.axim_en  = fld[1][0];
          rec.sys_cnt  = fld[2];
          rec.rvba     = fld[3];
          rec.apb_base = fld[4][39:0];
          // Per-core columns come in pairs of interrupts and code
          for (c = 0; c < NUM_CORES; c++)
          begin
            rec.irq[c]      = core_irq_t'(fld[5+2*c][5:0]);
            rec.lpmd[c]     = fld[6+2*c][1:0];
            rec.exp_irq[c]  = core_irq_t'(fld[13+2*c][5:0]);
            rec.exp_lpmd[c] = fld[14+2*c][1:0];
          end
          rec.mt_chk    = fld[9][0];
          rec.exp_mtime = fld[10];
          rec.exp_rvba  = fld[11];
          rec.exp_base  = fld[12][39:0];
          recs.push_back(rec);
        end
      end
      $fclose(fd);
      if (recs.size() == 0)
      begin
        $display("ERROR: trace file holds no records");
        errors = errors + 1;
      end
    end
    ok = (errors == 0);
  endtask

  // ==========================================================================
  // Drive and compare
  // ==========================================================================

  task automatic apply_record(input trace_rec_t rec);
    int c;
    apb_clk_en       = rec.apb_en;
    axim_clk_en      = rec.axim_en;
    pad_cpu_sys_cnt  = rec.sys_cnt;
    pad_cpu_rvba     = rec.rvba;
    pad_cpu_apb_base = rec.apb_base;
    for (c = 0; c < NUM_CORES; c++)
    begin
      core_irq_in[c]  = rec.irq[c];
      core_lpmd_in[c] = lpmd_e'(rec.lpmd[c]);
    end
  endtask

  task automatic compare_field(input string step, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
    checks = checks + 1;
    if (act !== exp)
    begin
      errors = errors + 1;
      $display("FAILED %0s %0s expected %h actual %h", step, what, exp, act);
    end
  endtask

  task automatic check_record(input trace_rec_t rec);
    int    c;
    string step;
    step = $sformatf("%0s", rec.name);
    // Timer is undefined until the first strobe
    if (rec.mt_chk)
      compare_field(step, "clint_mtime", rec.exp_mtime, clint_mtime);
    compare_field(step, "sysio_xx_rvba", rec.exp_rvba, sysio_xx_rvba);
    compare_field(step, "sysio_biu_apb_base", 64'(rec.exp_base), 64'(sysio_biu_apb_base));
    compare_field(step, "sysio_cp0_apb_base", 64'(rec.exp_base), 64'(sysio_cp0_apb_base));
    for (c = 0; c < NUM_CORES; c++)
    begin
      compare_field(step, $sformatf("core%0d irq", c),
                    64'(rec.exp_irq[c]), 64'(core_irq_out[c]));
      compare_field(step, $sformatf("core%0d lpmd", c),
                    64'(rec.exp_lpmd[c]), 64'(core_pad_lpmd[c]));
      // Fixed hart number per core
      compare_field(step, $sformatf("core%0d hartid", c),
                    64'(EXP_HARTID[c]), 64'(core_hartid[c]));
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial
  begin
    bit trace_ok;
    // Reset starts high so the asynchronous reset sees a falling edge
    cpurst_b           = 1'b1;
    apb_clk_en         = 1'b0;
    axim_clk_en        = 1'b0;
    pad_yy_icg_scan_en = 1'b0;
    pad_cpu_sys_cnt    = '0;
    pad_cpu_rvba       = '0;
    pad_cpu_apb_base   = '0;
    for (int c = 0; c < NUM_CORES; c++)
    begin
      core_irq_in[c]  = '0;
      core_lpmd_in[c] = LPMD_RUN;
    end
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    cycle_limit = 0;

    load_trace(trace_ok);
    if (trace_ok)
    begin
      cycle_limit = 10 * recs.size() + 20;
      // Reset vector must be on the pads while reset is applied
      pad_cpu_rvba = recs[0].rvba;
      #(CLK_PERIOD/4);
      cpurst_b = 1'b0;
      repeat (RESET_CYCLES) @(negedge apb_base_clk);
      cpurst_b = 1'b1;
      // Drive on the falling edge and check one full cycle later
      foreach (recs[i])
      begin
        apply_record(recs[i]);
        @(negedge apb_base_clk);
        check_record(recs[i]);
      end
    end

    $display("Summary: %0d records, %0d checks, %0d errors", recs.size(), checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule : tb_sysio

/* test/sysio_trace.txt */
# step apb_en axim_en sys_cnt rvba apb_base irq0 lpmd0 irq1 lpmd1 (stimulus, hex)
# then mt_chk exp_mtime exp_rvba exp_base exp_irq0 exp_lpmd0 exp_irq1 exp_lpmd1 (hex)
#
# Reset values, timer not yet sampled
reset_state   0 0 1111 80000000 0 00 3 00 3 0 0 80000000 0 00 3 00 3
#
# Timer sampling on axim_clk_en only
mtime_load    0 1 123456789abcdef 80000000 0 00 3 00 3 1 123456789abcdef 80000000 0 00 3 00 3
mtime_hold    0 0 fedcba9876543210 80000000 0 00 3 00 3 1 123456789abcdef 80000000 0 00 3 00 3
mtime_next    0 1 fedcba9876543210 80000000 0 00 3 00 3 1 fedcba9876543210 80000000 0 00 3 00 3
#
# Reset vector keeps the value seen around reset
rvba_change   0 0 5 1234abcd000 0 00 3 00 3 1 fedcba9876543210 80000000 0 00 3 00 3
#
# Bus base, upper 13 bits only, loads on axim_clk_en
base_hold     0 0 5 1234abcd000 123456789a 00 3 00 3 1 fedcba9876543210 80000000 0 00 3 00 3
base_load     0 1 5 1234abcd000 123456789a 00 3 00 3 1 5 80000000 1230000000 00 3 00 3
base_low_bits 0 1 6 1234abcd000 1237ffffff 00 3 00 3 1 6 80000000 1230000000 00 3 00 3
base_new      0 1 7 1234abcd000 ff80000000 00 3 00 3 1 7 80000000 ff80000000 00 3 00 3
base_keep     0 0 8 1234abcd000 0 00 3 00 3 1 7 80000000 ff80000000 00 3 00 3
#
# Interrupt retiming on apb_clk_en, cores carry different lines
irq_hold      0 0 8 1234abcd000 ff80000000 2a 3 15 3 1 7 80000000 ff80000000 00 3 00 3
irq_load      1 0 8 1234abcd000 ff80000000 2a 3 15 3 1 7 80000000 ff80000000 2a 3 15 3
irq_keep      0 0 8 1234abcd000 ff80000000 3f 3 00 3 1 7 80000000 ff80000000 2a 3 15 3
irq_swap      1 0 8 1234abcd000 ff80000000 01 3 20 3 1 7 80000000 ff80000000 01 3 20 3
#
# Low-power code on axim_clk_en
lpmd_hold     0 0 9 1234abcd000 ff80000000 01 0 20 2 1 7 80000000 ff80000000 01 3 20 3
lpmd_load     0 1 9 1234abcd000 ff80000000 01 0 20 2 1 9 80000000 ff80000000 01 0 20 2
lpmd_next     0 1 a 1234abcd000 ff80000000 01 1 20 2 1 a 80000000 ff80000000 01 1 20 2
lpmd_keep     0 0 b 1234abcd000 ff80000000 01 3 20 0 1 a 80000000 ff80000000 01 1 20 2
#
# Mixed steps
both_en       1 1 abc 1234abcd000 8000000 3f 2 00 1 1 abc 80000000 8000000 3f 2 00 1
base_zero     0 1 abd 1234abcd000 0 00 2 3f 1 1 abd 80000000 0 3f 2 00 1
rvba_final    0 0 abe ffffffffffffffff 0 00 2 3f 1 1 abd 80000000 0 3f 2 00 1

/* vlog.f */
src/sysio_pkg.sv
src/sysio_core_pkg.sv
src/gated_clk_cell.sv
src/sysio_core_ctrl.sv
src/sysio_top.sv
test/tb_sysio.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the system I/O testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f vlog.f --top-module tb_sysio \
  --Mdir obj_dir -o sim_sysio

output=$(./obj_dir/sim_sysio)
echo "$output"

if echo "$output" | grep -qxF 'All tests passed!'; then
  exit 0
fi
exit 1
